// File: tb/systolic_matmul_tests.txt
# name k groups, then per group a0 a1 b0 b1 in hex, beats cycle through the groups
# then c00 c01 c10 c11, each as expected result in hex and saturation bit
ident_k1 1 1 1000 2000 1000 f000 1000 0 f000 0 2000 0 e000 0
unit_k2 2 2 0001 0800 0800 1000 0001 f800 0001 0003 0001 0 0001 0 0400 0 07ff 0
neg_half_k1 1 1 ffff 0003 0800 1800 0000 0 ffff 0 0002 0 0005 0
ovf_k2 2 1 7fff 8000 7fff 8000 7fff 1 8000 1 8000 1 7fff 1
edge_k1 1 1 4000 1000 2000 e000 7fff 1 8000 0 2000 0 e000 0
long_sat 255 1 7fff 8000 8000 7fff 8000 1 7fff 1 7fff 1 8000 1
ident_again 1 1 0800 f800 0800 0800 0400 0 0400 0 fc00 0 fc00 0
long_small 255 1 0010 fff0 0011 0003 0011 0 0003 0 ffef 0 fffd 0
long_mix 255 2 1000 f000 0100 ff00 1000 f000 ff80 0080 4080 0 bf80 0 bf80 0 4080 0
diag_k3 3 3 1000 0000 1000 0000 0000 1000 0000 1000 0000 0000 0000 0000 1000 0 0000 0 0000 0 1000 0

// File: systolic_matmul.f
+incdir+design
design/systolic_matmul_pkg.sv
design/mac_pe.sv
design/pe_row.sv
design/result_merger.sv
design/systolic_matmul.sv
tb/systolic_matmul_sva.sv
tb/tb_systolic_matmul.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the systolic_matmul testbench with Verilator
LOG=sim.log

verilator --binary --timing -Wno-fatal -f systolic_matmul.f \
  --top-module tb_systolic_matmul -o tb_systolic_matmul
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_systolic_matmul > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb/tb_systolic_matmul.sv
`timescale 1ns/1ps
`default_nettype none

module tb_systolic_matmul;

  localparam int TIMEOUT_CYCLES = 1000;
  localparam int MAX_GROUPS = 256;

  logic                           clk;
  logic                           INTERNAL_RESET;
  logic                           in_valid;
  logic                           in_ready;
  logic                           in_last;
  systolic_matmul_pkg::operand_t  a0;
  systolic_matmul_pkg::operand_t  a1;
  systolic_matmul_pkg::operand_t  b0;
  systolic_matmul_pkg::operand_t  b1;
  logic                           res_valid;
  logic                           res_ready;
  systolic_matmul_pkg::operand_t  res_data;
  logic                           res_sat;
  logic                           res_last;

  // Current job as read from the tests file
  logic [8*32-1:0]                test_name;
  int                             num_steps;
  int                             num_groups;
  systolic_matmul_pkg::operand_t  grp_a0 [MAX_GROUPS];
  systolic_matmul_pkg::operand_t  grp_a1 [MAX_GROUPS];
  systolic_matmul_pkg::operand_t  grp_b0 [MAX_GROUPS];
  systolic_matmul_pkg::operand_t  grp_b1 [MAX_GROUPS];
  systolic_matmul_pkg::operand_t  exp_data [4];
  logic                           exp_sat [4];
  logic [31:0]                    rng_state;
  int                             fd;
  int                             jobs_run;

  systolic_matmul u_systolic_matmul (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic read_job(output logic found);
    logic [8*256-1:0] rest;
    int               cnt;
    int               g;
    int               i;
    int               sat_bit;
    found = 1'b0;
    cnt = $fscanf(fd, "%s", test_name);
    // Comment lines open with a lone hash
    while (cnt == 1 && test_name == "#") begin
      cnt = $fgets(rest, fd);
      cnt = $fscanf(fd, "%s", test_name);
    end
    if (cnt == 1) begin
      cnt = $fscanf(fd, "%d %d", num_steps, num_groups);
      assert (cnt == 2 && num_steps >= 1 && num_steps <= 255 &&
              num_groups >= 1 && num_groups <= num_steps) else begin
        $display("Test %0s has a bad step or group count in the tests file", test_name);
        abort_run();
      end
      for (g = 0; g < num_groups; g++) begin
        cnt = $fscanf(fd, "%h %h %h %h", grp_a0[g], grp_a1[g], grp_b0[g], grp_b1[g]);
        assert (cnt == 4) else begin
          $display("Test %0s has a broken operand group %0d", test_name, g);
          abort_run();
        end
      end
      for (i = 0; i < 4; i++) begin
        cnt = $fscanf(fd, "%h %d", exp_data[i], sat_bit);
        assert (cnt == 2) else begin
          $display("Test %0s is missing expected result %0d", test_name, i);
          abort_run();
        end
        exp_sat[i] = (sat_bit != 0);
      end
      found = 1'b1;
    end
  endtask

  // Beats cycle through the listed groups, with random idle gaps
  task automatic send_job();
    int k;
    int g;
    int gap;
    int waited;
    for (k = 0; k < num_steps; k++) begin
      rng_state = lcg_next(rng_state);
      gap = (rng_state[30:29] == 2'd0) ? int'(rng_state[28:27]) + 1 : 0;
      repeat (gap) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
      g = k % num_groups;
      @(negedge clk);
      in_valid = 1'b1;
      in_last  = (k == num_steps - 1);
      a0 = grp_a0[g];
      a1 = grp_a1[g];
      b0 = grp_b0[g];
      b1 = grp_b1[g];
      waited = 0;
      while (in_ready !== 1'b1) begin
        @(negedge clk);
        waited++;
        assert (waited < TIMEOUT_CYCLES) else begin
          $display("Timeout in test %0s: in_ready stayed low at step %0d", test_name, k);
          abort_run();
        end
      end
    end
    @(negedge clk);
    in_valid  = 1'b0;
    in_last   = 1'b0;
    res_ready = 1'b0;
  endtask

  // Random back-pressure, each result checked before its transfer edge
  task automatic collect_results();
    int i;
    int waited;
    for (i = 0; i < 4; i++) begin
      waited = 0;
      do begin
        @(negedge clk);
        rng_state = lcg_next(rng_state);
        res_ready = (rng_state[31:30] != 2'd0);
        waited++;
        assert (waited < TIMEOUT_CYCLES) else begin
          $display("Timeout in test %0s: result %0d never transferred", test_name, i);
          abort_run();
        end
      end while (!(res_valid === 1'b1 && res_ready === 1'b1));
      assert (res_data === exp_data[i] && res_sat === exp_sat[i]) else begin
        $display("[ERROR] %0s c%0d%0d: expected %h sat %0d, actual %h sat %0d", test_name,
                 i / 2, i % 2, exp_data[i], exp_sat[i], res_data, res_sat);
        abort_run();
      end
      assert (res_last === (i == 3)) else begin
        $display("[ERROR] %0s c%0d%0d res_last: expected %0d, actual %0d", test_name,
                 i / 2, i % 2, (i == 3), res_last);
        abort_run();
      end
    end
  endtask

  initial begin
    logic found;
    INTERNAL_RESET = 1'b1;
    in_valid  = 1'b0;
    in_last   = 1'b0;
    a0        = '0;
    a1        = '0;
    b0        = '0;
    b1        = '0;
    res_ready = 1'b0;
    rng_state = 32'hf417;
    jobs_run  = 0;
    fd = $fopen("tb/systolic_matmul_tests.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open tb/systolic_matmul_tests.txt");
      abort_run();
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    INTERNAL_RESET = 1'b0;
    // Jobs run back to back with no reset in between
    read_job(found);
    while (found) begin
      send_job();
      collect_results();
      jobs_run++;
      read_job(found);
    end
    $fclose(fd);
    if (jobs_run > 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("No jobs were found in the tests file");
      abort_run();
    end
  end

endmodule

`default_nettype wire

// File: tb/systolic_matmul_sva.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_matmul_sva (
  input logic                           clk,
  input logic                           INTERNAL_RESET,
  input logic                           in_ready,
  input logic                           res_valid,
  input logic                           res_ready,
  input systolic_matmul_pkg::operand_t  res_data,
  input logic                           res_last
);

  // A stalled result keeps its value
  res_hold_a: assert property (
    @(posedge clk) disable iff (INTERNAL_RESET)
      (res_valid && !res_ready) |=> $stable(res_data))
    else $error("res_data changed while the result stream was stalled");

  // Rows come out of reset collecting
  ready_after_reset_a: assert property (
    @(posedge clk) $fell(INTERNAL_RESET) |-> in_ready)
    else $error("in_ready is low right after reset");

  res_last_valid_a: assert property (
    @(posedge clk) disable iff (INTERNAL_RESET)
      res_last |-> res_valid)
    else $error("res_last seen without res_valid");

endmodule

bind systolic_matmul systolic_matmul_sva u_sva (.*);

`default_nettype wire

// File: design/systolic_matmul.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_matmul (
  input  logic                           clk,
  input  logic                           INTERNAL_RESET,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic                           in_last,
  input  systolic_matmul_pkg::operand_t  a0,
  input  systolic_matmul_pkg::operand_t  a1,
  input  systolic_matmul_pkg::operand_t  b0,
  input  systolic_matmul_pkg::operand_t  b1,
  output logic                           res_valid,
  input  logic                           res_ready,
  output systolic_matmul_pkg::operand_t  res_data,
  output logic                           res_sat,
  output logic                           res_last
);

  logic                       row0_ready;
  logic                       row1_ready;
  logic                       row0_valid;
  logic                       row1_valid;
  logic                       acc_release;
  systolic_matmul_pkg::acc_t  row0_acc0;
  systolic_matmul_pkg::acc_t  row0_acc1;
  systolic_matmul_pkg::acc_t  row1_acc0;
  systolic_matmul_pkg::acc_t  row1_acc1;

  // Row 0 computes c00/c01 from A row 0
  pe_row u_row0 (
    .clk            (clk),
    .INTERNAL_RESET (INTERNAL_RESET),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_last        (in_last),
    .a_in           (a0),
    .b0             (b0),
    .b1             (b1),
    .acc_release    (acc_release),
    .row_ready      (row0_ready),
    .acc_valid      (row0_valid),
    .acc0           (row0_acc0),
    .acc1           (row0_acc1)
  );

  // Row 1 computes c10/c11 from A row 1
  pe_row u_row1 (
    .clk            (clk),
    .INTERNAL_RESET (INTERNAL_RESET),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_last        (in_last),
    .a_in           (a1),
    .b0             (b0),
    .b1             (b1),
    .acc_release    (acc_release),
    .row_ready      (row1_ready),
    .acc_valid      (row1_valid),
    .acc0           (row1_acc0),
    .acc1           (row1_acc1)
  );

  result_merger u_merger (
    .clk            (clk),
    .INTERNAL_RESET (INTERNAL_RESET),
    .row0_ready     (row0_ready),
    .row1_ready     (row1_ready),
    .in_ready       (in_ready),
    .row0_valid     (row0_valid),
    .row1_valid     (row1_valid),
    .row0_acc0      (row0_acc0),
    .row0_acc1      (row0_acc1),
    .row1_acc0      (row1_acc0),
    .row1_acc1      (row1_acc1),
    .acc_release    (acc_release),
    .res_valid      (res_valid),
    .res_ready      (res_ready),
    .res_data       (res_data),
    .res_sat        (res_sat),
    .res_last       (res_last)
  );

endmodule

`default_nettype wire

// File: design/result_merger.sv
`timescale 1ns/1ps
`default_nettype none

`include "systolic_matmul_defs.svh"

module result_merger (
  input  logic                           clk,
  input  logic                           INTERNAL_RESET,
  input  logic                           row0_ready,
  input  logic                           row1_ready,
  output logic                           in_ready,
  input  logic                           row0_valid,
  input  logic                           row1_valid,
  input  systolic_matmul_pkg::acc_t      row0_acc0,
  input  systolic_matmul_pkg::acc_t      row0_acc1,
  input  systolic_matmul_pkg::acc_t      row1_acc0,
  input  systolic_matmul_pkg::acc_t      row1_acc1,
  output logic                           acc_release,
  output logic                           res_valid,
  input  logic                           res_ready,
  output systolic_matmul_pkg::operand_t  res_data,
  output logic                           res_sat,
  output logic                           res_last
);

  systolic_matmul_pkg::merge_state_t  state;
  systolic_matmul_pkg::acc_t          sel_acc;
  systolic_matmul_pkg::acc_t          rounded;
  systolic_matmul_pkg::acc_t          scaled;

  // Both rows must be collecting before a beat can enter
  assign in_ready = row0_ready & row1_ready;

  assign res_valid   = (state != systolic_matmul_pkg::IDLE);
  assign res_last    = (state == systolic_matmul_pkg::EMIT11);
  assign acc_release = (state == systolic_matmul_pkg::EMIT11) & res_ready;

  // Step on each transfer, start once both rows hold their sums
  always_ff @(posedge clk) begin
    if (INTERNAL_RESET) begin
      state <= systolic_matmul_pkg::IDLE;
    end else begin
      case (state)
        systolic_matmul_pkg::IDLE: begin
          if (row0_valid && row1_valid) begin
            state <= systolic_matmul_pkg::EMIT00;
          end
        end
        systolic_matmul_pkg::EMIT00: begin
          if (res_ready) begin
            state <= systolic_matmul_pkg::EMIT01;
          end
        end
        systolic_matmul_pkg::EMIT01: begin
          if (res_ready) begin
            state <= systolic_matmul_pkg::EMIT10;
          end
        end
        systolic_matmul_pkg::EMIT10: begin
          if (res_ready) begin
            state <= systolic_matmul_pkg::EMIT11;
          end
        end
        systolic_matmul_pkg::EMIT11: begin
          if (res_ready) begin
            state <= systolic_matmul_pkg::IDLE;
          end
        end
        default: begin
          state <= systolic_matmul_pkg::IDLE;
        end
      endcase
    end
  end

  // Row 0 holds c00/c01, row 1 holds c10/c11
  always_comb begin
    case (state)
      systolic_matmul_pkg::EMIT01: sel_acc = row0_acc1;
      systolic_matmul_pkg::EMIT10: sel_acc = row1_acc0;
      systolic_matmul_pkg::EMIT11: sel_acc = row1_acc1;
      default:                     sel_acc = row0_acc0;
    endcase
  end

  // Round half up, then drop the extra fraction bits
  assign rounded = sel_acc + systolic_matmul_pkg::acc_t'(1 << (`MM_FRAC - 1));
  assign scaled  = rounded >>> `MM_FRAC;

  // Clip to the Q4.12 range
  always_comb begin
    if (scaled > `MM_SAT_MAX) begin
      res_data = systolic_matmul_pkg::operand_t'(`MM_SAT_MAX);
      res_sat  = 1'b1;
    end else if (scaled < `MM_SAT_MIN) begin
      res_data = systolic_matmul_pkg::operand_t'(`MM_SAT_MIN);
      res_sat  = 1'b1;
    end else begin
      res_data = scaled[`MM_OP_W-1:0];
      res_sat  = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/pe_row.sv
`timescale 1ns/1ps
`default_nettype none

module pe_row (
  input  logic                           clk,
  input  logic                           INTERNAL_RESET,
  input  logic                           in_valid,
  input  logic                           in_ready,
  input  logic                           in_last,
  input  systolic_matmul_pkg::operand_t  a_in,
  input  systolic_matmul_pkg::operand_t  b0,
  input  systolic_matmul_pkg::operand_t  b1,
  input  logic                           acc_release,
  output logic                           row_ready,
  output logic                           acc_valid,
  output systolic_matmul_pkg::acc_t      acc0,
  output systolic_matmul_pkg::acc_t      acc1
);

  typedef enum logic [1:0] {
    ROW_COLLECT,
    ROW_DRAIN,
    ROW_HOLD
  } row_state_t;

  row_state_t                     state;
  logic                           accept;
  logic                           pe1_en;
  systolic_matmul_pkg::operand_t  a_mid;
  systolic_matmul_pkg::operand_t  b1_skew;

  assign accept    = in_valid & in_ready;
  assign row_ready = (state == ROW_COLLECT);

  // Column 1 runs one cycle behind column 0
  always_ff @(posedge clk) begin
    if (INTERNAL_RESET) begin
      pe1_en <= 1'b0;
    end else begin
      pe1_en <= accept;
    end
  end

  // B of column 1 waits for its A to arrive from pe0
  always_ff @(posedge clk) begin
    if (accept) begin
      b1_skew <= b1;
    end
  end

  // Collect until in_last, let pe1 finish, then hold for the merger
  always_ff @(posedge clk) begin
    if (INTERNAL_RESET) begin
      state     <= ROW_COLLECT;
      acc_valid <= 1'b0;
    end else begin
      case (state)
        ROW_COLLECT: begin
          if (accept && in_last) begin
            state <= ROW_DRAIN;
          end
        end
        ROW_DRAIN: begin
          state <= ROW_HOLD;
        end
        ROW_HOLD: begin
          if (acc_release) begin
            state     <= ROW_COLLECT;
            acc_valid <= 1'b0;
          end else begin
            acc_valid <= 1'b1;
          end
        end
        default: begin
          state     <= ROW_COLLECT;
          acc_valid <= 1'b0;
        end
      endcase
    end
  end

  mac_pe pe0 (
    .clk            (clk),
    .INTERNAL_RESET (INTERNAL_RESET),
    .en             (accept),
    .clear          (acc_release),
    .a_in           (a_in),
    .b_in           (b0),
    .a_out          (a_mid),
    .acc            (acc0)
  );

  // Last element in the row, its A output goes nowhere
  mac_pe pe1 (
    .clk            (clk),
    .INTERNAL_RESET (INTERNAL_RESET),
    .en             (pe1_en),
    .clear          (acc_release),
    .a_in           (a_mid),
    .b_in           (b1_skew),
    .a_out          (),
    .acc            (acc1)
  );

endmodule

`default_nettype wire

// File: design/mac_pe.sv
`timescale 1ns/1ps
`default_nettype none

`include "systolic_matmul_defs.svh"

module mac_pe (
  input  logic                           clk,
  input  logic                           INTERNAL_RESET,
  input  logic                           en,
  input  logic                           clear,
  input  systolic_matmul_pkg::operand_t  a_in,
  input  systolic_matmul_pkg::operand_t  b_in,
  output systolic_matmul_pkg::operand_t  a_out,
  output systolic_matmul_pkg::acc_t      acc
);

  // Full-width signed product of both operands
  logic signed [2*`MM_OP_W-1:0] prod;
  systolic_matmul_pkg::acc_t    prod_ext;

  assign prod = a_in * b_in;

  // Sign extend into the guard bits
  assign prod_ext = {{(`MM_ACC_W - 2*`MM_OP_W){prod[2*`MM_OP_W-1]}}, prod};

  // Clear wins over a new step
  always_ff @(posedge clk) begin
    if (INTERNAL_RESET || clear) begin
      acc <= '0;
    end else if (en) begin
      acc <= acc + prod_ext;
    end
  end

  // A moves one element to the right per step
  always_ff @(posedge clk) begin
    if (en) begin
      a_out <= a_in;
    end
  end

endmodule

`default_nettype wire

// File: design/systolic_matmul_pkg.sv
`default_nettype none

`include "systolic_matmul_defs.svh"

package systolic_matmul_pkg;

  // Q4.12 operand, also used for results
  typedef logic signed [`MM_OP_W-1:0] operand_t;

  // Raw dot-product sum before rounding
  typedef logic signed [`MM_ACC_W-1:0] acc_t;

  // Merger walks the four results in output order
  typedef enum logic [2:0] {
    IDLE,
    EMIT00,
    EMIT01,
    EMIT10,
    EMIT11
  } merge_state_t;

endpackage

`default_nettype wire

// File: design/systolic_matmul_defs.svh
`ifndef SYSTOLIC_MATMUL_DEFS_SVH
`define SYSTOLIC_MATMUL_DEFS_SVH

// Operand and result width, signed Q4.12
`define MM_OP_W 16

// Fraction bits of operands and results
`define MM_FRAC 12

// Full product plus 8 guard bits, enough for K up to 255
`define MM_ACC_W 40

// Width of the step count, K runs 1..255
`define MM_K_W 8

// Clip bounds of the Q4.12 result
`define MM_SAT_MAX 32767
`define MM_SAT_MIN (-32768)

`endif
